// File: receiver_centre.f
src/bt_rx_pkg.sv
src/uart_rx.sv
src/rx_fifo.sv
src/command_decoder.sv
src/receiver_centre.sv
dv/receiver_centre_tb.sv

// File: dv/receiver_centre_tb.sv
// Frames run at 16 cycles per bit with a 64 cycle idle limit.
// The overflow test sends more than 8192 bytes, so the run spans several ms of sim time.
`timescale 1ns/10ps

module receiver_centre_tb;

	localparam int clock_ns = 4;
	localparam int bit_cycles = 16;
	localparam int idle_cycles = 64;
	localparam int max_gap = 40;
	localparam int overflow_extra = 6;

	// Bytes sent by all tests together, and the run limit derived from them.
	localparam int total_bytes = 32 + 28 + 8 + bt_rx_pkg::fifo_bytes + overflow_extra;
	localparam int burst_count = 9;
	localparam int frame_ns = 10 * bit_cycles * clock_ns;
	localparam int gap_ns = max_gap * clock_ns;
	localparam int margin_ns = (idle_cycles * 4 + 64) * clock_ns;
	localparam int read_ns = (total_bytes / 2 + 16) * 2 * clock_ns;
	localparam int watchdog_ns =
		2 * (total_bytes * (frame_ns + gap_ns) + burst_count * margin_ns + read_ns + 100);

	typedef enum logic [3:0]
	{
		chk_fifo_data,
		chk_full,
		chk_empty,
		chk_wr_count,
		chk_rd_count,
		chk_sending,
		chk_select,
		chk_at_complete,
		chk_complete_count
	} check_kind_t;

	typedef struct packed
	{
		check_kind_t kind;
		logic [15:0] expected;
	} check_t;

	logic clock;
	logic reset;
	logic link_up;
	logic serial_in;
	logic rd_en;
	logic [bt_rx_pkg::bit_period_width-1:0] cycles_per_bit;
	logic [bt_rx_pkg::bit_period_width-1:0] idle_limit;
	logic at_complete;
	logic [15:0] fifo_data;
	bt_rx_pkg::fifo_status_t fifo_status;
	logic [7:0] stream_select;
	logic sending;

	// Reference model state.
	logic [7:0] model_bytes[$];
	logic model_phase;
	logic [7:0] model_op;
	logic [7:0] model_operand;
	logic model_sending;
	logic [7:0] model_select;

	logic [7:0] burst_q[$];
	check_t check_q[$];
	check_t req;
	logic [15:0] actual;
	string signal_name;
	event compare_event;
	int complete_count;
	int complete_start;
	int check_count;
	int error_count;
	int test_error_start;

	receiver_centre UUT
	(
		.clock(clock),
		.reset(reset),
		.link_up(link_up),
		.serial_in(serial_in),
		.cycles_per_bit(cycles_per_bit),
		.idle_limit(idle_limit),
		.at_complete(at_complete),
		.rd_en(rd_en),
		.fifo_data(fifo_data),
		.fifo_status(fifo_status),
		.stream_select(stream_select),
		.sending(sending)
	);

	always #(clock_ns / 2) clock = ~clock;

	always @(negedge clock)
	begin
		if (at_complete)
			complete_count = complete_count + 1;
	end

	function automatic void model_write(input logic [7:0] value);
		if (model_bytes.size() < bt_rx_pkg::fifo_bytes)
			model_bytes.push_back(value);
	endfunction

	// First byte of the pair is the high half.
	function automatic logic [15:0] model_read();
		logic [15:0] half;
		half[15:8] = model_bytes.pop_front();
		half[7:0] = model_bytes.pop_front();
		return half;
	endfunction

	function automatic bt_rx_pkg::fifo_status_t model_status();
		bt_rx_pkg::fifo_status_t s;
		int n;
		int halves;
		n = model_bytes.size();
		halves = n / 2;
		s.full = (n == bt_rx_pkg::fifo_bytes);
		s.empty = (halves == 0);
		s.wr_count = n[bt_rx_pkg::wr_count_width-1:0];
		s.rd_count = halves[bt_rx_pkg::rd_count_width-1:0];
		return s;
	endfunction

	function automatic void model_command_byte(input logic [7:0] value);
		if (model_phase)
			model_operand = value;
		else
			model_op = value;
		model_phase = ~model_phase;
	endfunction

	// Last pair of the burst is applied.
	function automatic void model_burst_end();
		if (model_op == 8'h00)
		begin
			model_select = model_operand;
			model_sending = 1'b1;
		end
		else if (model_op == 8'h01)
			model_sending = 1'b0;
	endfunction

	task automatic expect_value(input check_kind_t kind, input logic [15:0] value);
		check_t c;
		c.kind = kind;
		c.expected = value;
		check_q.push_back(c);
		-> compare_event;
	endtask

	always
	begin
		@(compare_event);
		while (check_q.size() > 0)
		begin
			req = check_q.pop_front();
			case (req.kind)
				chk_fifo_data:
				begin
					actual = fifo_data;
					signal_name = "fifo_data";
				end
				chk_full:
				begin
					actual = {15'd0, fifo_status.full};
					signal_name = "fifo_status.full";
				end
				chk_empty:
				begin
					actual = {15'd0, fifo_status.empty};
					signal_name = "fifo_status.empty";
				end
				chk_wr_count:
				begin
					actual = {3'd0, fifo_status.wr_count};
					signal_name = "fifo_status.wr_count";
				end
				chk_rd_count:
				begin
					actual = {4'd0, fifo_status.rd_count};
					signal_name = "fifo_status.rd_count";
				end
				chk_sending:
				begin
					actual = {15'd0, sending};
					signal_name = "sending";
				end
				chk_select:
				begin
					actual = {8'd0, stream_select};
					signal_name = "stream_select";
				end
				chk_at_complete:
				begin
					actual = {15'd0, at_complete};
					signal_name = "at_complete";
				end
				default:
				begin
					actual = complete_count[15:0];
					signal_name = "at_complete pulse count";
				end
			endcase
			check_count = check_count + 1;
			if (actual !== req.expected)
			begin
				$display("[ERROR] %0t ns %s expected %0h actual %0h",
					$time, signal_name, req.expected, actual);
				error_count = error_count + 1;
			end
		end
	end

	task automatic check_status();
		bt_rx_pkg::fifo_status_t s;
		s = model_status();
		expect_value(chk_full, {15'd0, s.full});
		expect_value(chk_empty, {15'd0, s.empty});
		expect_value(chk_wr_count, {3'd0, s.wr_count});
		expect_value(chk_rd_count, {4'd0, s.rd_count});
	endtask

	// One 8N1 frame, then the line stays idle for gap cycles.
	task automatic send_frame(input logic [7:0] value, input int gap);
		int i;
		serial_in = 1'b0;
		repeat (bit_cycles) @(negedge clock);
		for (i = 0; i < 8; i++)
		begin
			serial_in = value[i];
			repeat (bit_cycles) @(negedge clock);
		end
		serial_in = 1'b1;
		repeat (bit_cycles + gap) @(negedge clock);
	endtask

	task automatic fill_random(input int count);
		burst_q.delete();
		repeat (count) burst_q.push_back($urandom_range(255, 0));
	endtask

	task automatic send_burst();
		int i;
		int gap;
		complete_start = complete_count;
		for (i = 0; i < burst_q.size(); i++)
		begin
			if (i == burst_q.size() - 1)
				gap = 0;
			else
				gap = $urandom_range(max_gap, 0);
			send_frame(burst_q[i], gap);
			if (link_up)
				model_command_byte(burst_q[i]);
			else
				model_write(burst_q[i]);
		end
	endtask

	task automatic wait_complete();
		int cycles;
		cycles = 0;
		while (complete_count == complete_start && cycles < idle_cycles * 4)
		begin
			@(negedge clock);
			cycles++;
		end
		if (complete_count == complete_start)
		begin
			$display("at_complete did not pulse within %0d cycles after the burst", cycles);
			error_count = error_count + 1;
		end
	endtask

	task automatic finish_burst();
		if (!link_up)
		begin
			// No pulse may appear while the burst is still arriving.
			expect_value(chk_complete_count, complete_start[15:0]);
			wait_complete();
			repeat (idle_cycles + 16) @(negedge clock);
			expect_value(chk_complete_count, complete_start[15:0] + 16'd1);
		end
		else
		begin
			repeat (idle_cycles + 32) @(negedge clock);
			model_burst_end();
			expect_value(chk_complete_count, complete_start[15:0]);
			expect_value(chk_sending, {15'd0, model_sending});
			expect_value(chk_select, {8'd0, model_select});
		end
		expect_value(chk_at_complete, 16'd0);
		check_status();
		@(negedge clock);
	endtask

	task automatic read_halfword();
		logic had_data;
		had_data = (model_bytes.size() >= 2);
		rd_en = 1'b1;
		@(negedge clock);
		rd_en = 1'b0;
		if (had_data)
			expect_value(chk_fifo_data, model_read());
		check_status();
	endtask

	task automatic drain_fifo();
		while (model_bytes.size() >= 2)
			read_halfword();
	endtask

	task automatic report_test(input int number, input string title);
		-> compare_event;
		@(negedge clock);
		$display("test %0d %s finished with %0d errors",
			number, title, error_count - test_error_start);
		test_error_start = error_count;
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hf8549330));
		clock = 1'b0;
		reset = 1'b1;
		link_up = 1'b0;
		serial_in = 1'b1;
		rd_en = 1'b0;
		cycles_per_bit = bit_cycles;
		idle_limit = idle_cycles;
		model_phase = 1'b0;
		model_op = 8'h00;
		model_operand = 8'h00;
		model_sending = 1'b0;
		model_select = 8'h00;
		complete_count = 0;
		complete_start = 0;
		check_count = 0;
		error_count = 0;
		test_error_start = 0;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		expect_value(chk_at_complete, 16'd0);
		expect_value(chk_sending, 16'd0);
		expect_value(chk_select, 16'd0);
		check_status();
		report_test(1, "reset state");

		fill_random(32);
		send_burst();
		finish_burst();
		drain_fifo();
		report_test(2, "command mode write and read");

		// Two command bursts, then one data burst.
		repeat (2)
		begin
			fill_random(10);
			send_burst();
			finish_burst();
		end
		drain_fifo();
		link_up = 1'b1;
		fill_random(8);
		send_burst();
		finish_burst();
		link_up = 1'b0;
		@(negedge clock);
		report_test(3, "completion pulse by mode");

		link_up = 1'b1;
		burst_q.delete();
		burst_q.push_back(bt_rx_pkg::cmd_start);
		burst_q.push_back($urandom_range(255, 0));
		send_burst();
		finish_burst();
		burst_q.delete();
		burst_q.push_back($urandom_range(255, 2));
		burst_q.push_back($urandom_range(255, 0));
		send_burst();
		finish_burst();
		burst_q.delete();
		burst_q.push_back(bt_rx_pkg::cmd_cancel);
		burst_q.push_back($urandom_range(255, 0));
		send_burst();
		finish_burst();
		burst_q.delete();
		burst_q.push_back($urandom_range(255, 2));
		burst_q.push_back($urandom_range(255, 0));
		send_burst();
		finish_burst();
		link_up = 1'b0;
		@(negedge clock);
		report_test(4, "data mode commands");

		fill_random(bt_rx_pkg::fifo_bytes + overflow_extra);
		send_burst();
		finish_burst();
		drain_fifo();
		expect_value(chk_empty, 16'd1);
		read_halfword();
		report_test(5, "overflow and drain");

		-> compare_event;
		@(negedge clock);
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: src/receiver_centre.sv
// Serial receiver for a radio module. Link down sends bytes to the FIFO, link up to commands.
// A burst ends after idle_limit quiet cycles; link_up should not change inside a burst.
`timescale 1ns/10ps

module receiver_centre
(
	input logic clock,
	input logic reset,
	input logic link_up,
	input logic serial_in,
	input logic [bt_rx_pkg::bit_period_width-1:0] cycles_per_bit,
	input logic [bt_rx_pkg::bit_period_width-1:0] idle_limit,
	output logic at_complete,
	input logic rd_en,
	output logic [15:0] fifo_data,
	output bt_rx_pkg::fifo_status_t fifo_status,
	output logic [7:0] stream_select,
	output logic sending
);

	bt_rx_pkg::rx_byte_t rx_byte;
	bt_rx_pkg::rx_byte_t cmd_byte;
	bt_rx_pkg::burst_state_t state;
	bt_rx_pkg::burst_state_t next_state;
	logic busy;
	logic fifo_wr_en;
	logic burst_end;
	logic [bt_rx_pkg::bit_period_width-1:0] idle_timer;

	uart_rx rx
	(
		.clock(clock),
		.reset(reset),
		.cycles_per_bit(cycles_per_bit),
		.serial_in(serial_in),
		.rx_byte(rx_byte),
		.busy(busy)
	);

	// Command mode bytes.
	assign fifo_wr_en = rx_byte.valid & ~link_up;

	rx_fifo fifo
	(
		.clock(clock),
		.reset(reset),
		.wr_en(fifo_wr_en),
		.din(rx_byte.data),
		.rd_en(rd_en),
		.dout(fifo_data),
		.status(fifo_status)
	);

	// Data mode bytes.
	assign cmd_byte = '{data: rx_byte.data, valid: rx_byte.valid & link_up};

	command_decoder decoder
	(
		.clock(clock),
		.reset(reset),
		.rx_byte(cmd_byte),
		.burst_end(burst_end),
		.stream_select(stream_select),
		.sending(sending)
	);

	assign at_complete = (state == bt_rx_pkg::done) & ~link_up;
	assign burst_end = (state == bt_rx_pkg::done) & link_up;

	// A new start bit during the quiet wait restarts collection.
	always_comb
	begin
		next_state = state;
		case (state)
			bt_rx_pkg::collecting:
			begin
				if (rx_byte.valid)
					next_state = bt_rx_pkg::checking;
			end
			bt_rx_pkg::checking:
			begin
				if (busy)
					next_state = bt_rx_pkg::collecting;
				else if (idle_timer == idle_limit)
					next_state = bt_rx_pkg::done;
			end
			default:
			begin
				next_state = bt_rx_pkg::collecting;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= bt_rx_pkg::collecting;
			idle_timer <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == bt_rx_pkg::checking)
				idle_timer <= idle_timer + 1'b1;
			else
				idle_timer <= '0;
		end
	end

endmodule

// File: src/command_decoder.sv
// Pairs data mode bytes as opcode then operand; the last pair of a burst is applied.
// Pairing continues across bursts, so an odd burst shifts the next pairing.
`timescale 1ns/10ps

module command_decoder
(
	input logic clock,
	input logic reset,
	input bt_rx_pkg::rx_byte_t rx_byte,
	input logic burst_end,
	output logic [7:0] stream_select,
	output logic sending
);

	// Low while waiting for an opcode, high while waiting for its operand.
	logic phase;
	logic [7:0] opcode_q;
	logic [7:0] operand_q;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			phase <= 1'b0;
			opcode_q <= 8'h00;
			operand_q <= 8'h00;
		end
		else if (rx_byte.valid)
		begin
			phase <= ~phase;
			if (phase)
				operand_q <= rx_byte.data;
			else
				opcode_q <= rx_byte.data;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			stream_select <= 8'h00;
			sending <= 1'b0;
		end
		else if (burst_end)
		begin
			case (bt_rx_pkg::cmd_op_t'(opcode_q))
				bt_rx_pkg::cmd_start:
				begin
					stream_select <= operand_q;
					sending <= 1'b1;
				end
				bt_rx_pkg::cmd_cancel:
				begin
					sending <= 1'b0;
				end
				default:
				begin
					// Outputs hold for unknown opcodes.
				end
			endcase
		end
	end

endmodule

// File: src/rx_fifo.sv
// Byte in, halfword out FIFO. The first byte of a pair is the high half.
// Counts wrap to zero at capacity; use full to tell full from empty.
`timescale 1ns/10ps

module rx_fifo
(
	input logic clock,
	input logic reset,
	input logic wr_en,
	input logic [7:0] din,
	input logic rd_en,
	output logic [15:0] dout,
	output bt_rx_pkg::fifo_status_t status
);

	logic [7:0] mem [bt_rx_pkg::fifo_bytes];

	// One extra bit on each pointer separates full from empty.
	logic [bt_rx_pkg::fifo_addr_width:0] wr_ptr;
	logic [bt_rx_pkg::fifo_addr_width:0] rd_ptr;
	logic [bt_rx_pkg::fifo_addr_width:0] fill;
	logic [bt_rx_pkg::fifo_addr_width-1:0] wr_addr;
	logic [bt_rx_pkg::fifo_addr_width-1:0] rd_addr_hi;
	logic [bt_rx_pkg::fifo_addr_width-1:0] rd_addr_lo;
	logic full;
	logic empty;
	logic do_write;
	logic do_read;

	assign fill = wr_ptr - rd_ptr;
	assign full = (fill == bt_rx_pkg::fifo_bytes);

	// Empty means no complete halfword.
	assign empty = (fill[bt_rx_pkg::fifo_addr_width:1] == '0);

	assign do_write = wr_en & ~full;
	assign do_read = rd_en & ~empty;

	assign wr_addr = wr_ptr[bt_rx_pkg::fifo_addr_width-1:0];
	assign rd_addr_hi = rd_ptr[bt_rx_pkg::fifo_addr_width-1:0];
	assign rd_addr_lo = rd_addr_hi + 1'b1;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 2'd2;
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_write)
			mem[wr_addr] <= din;
		if (do_read)
			dout <= {mem[rd_addr_hi], mem[rd_addr_lo]};
	end

	// Halfword count drops the odd trailing byte.
	assign status.full = full;
	assign status.empty = empty;
	assign status.wr_count = fill[bt_rx_pkg::wr_count_width-1:0];
	assign status.rd_count = fill[bt_rx_pkg::rd_count_width:1];

endmodule

// File: src/uart_rx.sv
// 8N1 serial receiver. cycles_per_bit must be at least 4 and held stable during a frame.
// A stop bit sampled low drops the byte silently.
`timescale 1ns/10ps

module uart_rx
(
	input logic clock,
	input logic reset,
	input logic [bt_rx_pkg::bit_period_width-1:0] cycles_per_bit,
	input logic serial_in,
	output bt_rx_pkg::rx_byte_t rx_byte,
	output logic busy
);

	logic serial_meta;
	logic serial_sync;
	logic serial_prev;
	logic start_edge;
	logic sample_point;
	logic [bt_rx_pkg::bit_period_width-1:0] cycle_count;
	logic [bt_rx_pkg::bit_period_width-1:0] half_period;
	logic [3:0] bit_count;
	logic [7:0] shift_reg;
	logic [7:0] data_q;
	logic valid_q;

	assign start_edge = serial_prev & ~serial_sync;
	assign half_period = cycles_per_bit >> 1;

	// Start bit is checked at mid period, the rest at whole periods.
	always_comb
	begin
		if (bit_count == 4'd0)
			sample_point = (cycle_count == half_period);
		else
			sample_point = (cycle_count == cycles_per_bit - 1'b1);
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			serial_meta <= 1'b1;
			serial_sync <= 1'b1;
			serial_prev <= 1'b1;
			busy <= 1'b0;
			cycle_count <= '0;
			bit_count <= 4'd0;
			valid_q <= 1'b0;
		end
		else
		begin
			serial_meta <= serial_in;
			serial_sync <= serial_meta;
			serial_prev <= serial_sync;
			valid_q <= 1'b0;
			if (!busy)
			begin
				cycle_count <= '0;
				bit_count <= 4'd0;
				if (start_edge)
					busy <= 1'b1;
			end
			else if (sample_point)
			begin
				cycle_count <= '0;
				if (bit_count == 4'd0 && serial_sync)
					busy <= 1'b0;
				else if (bit_count == 4'd9)
				begin
					busy <= 1'b0;
					valid_q <= serial_sync;
				end
				else
					bit_count <= bit_count + 4'd1;
			end
			else
				cycle_count <= cycle_count + 1'b1;
		end
	end

	// Data arrives least significant bit first.
	always_ff @(posedge clock)
	begin
		if (busy && sample_point && bit_count != 4'd0 && bit_count != 4'd9)
			shift_reg <= {serial_sync, shift_reg[7:1]};
		if (busy && sample_point && bit_count == 4'd9)
			data_q <= shift_reg;
	end

	assign rx_byte = '{data: data_q, valid: valid_q};

endmodule

// File: src/bt_rx_pkg.sv
// Sizes, opcodes and shared types for the serial receiver.
// Counts are narrower than a full buffer needs, so they wrap to zero when full.
package bt_rx_pkg;

	// Cycles per bit and the idle limit share this width.
	localparam int bit_period_width = 10;

	// Receive buffer geometry.
	localparam int fifo_bytes = 8192;
	localparam int fifo_addr_width = $clog2(fifo_bytes);

	// Byte count on the write side, halfword count on the read side.
	localparam int wr_count_width = 13;
	localparam int rd_count_width = 12;

	// Data mode opcodes.
	typedef enum logic [7:0]
	{
		cmd_start = 8'h00,
		cmd_cancel = 8'h01
	} cmd_op_t;

	// End of burst detector.
	typedef enum logic [1:0]
	{
		collecting = 2'b00,
		checking = 2'b01,
		done = 2'b10
	} burst_state_t;

	// One received byte; valid is a single cycle strobe.
	typedef struct packed
	{
		logic [7:0] data;
		logic valid;
	} rx_byte_t;

	// Receive FIFO flags and counts.
	typedef struct packed
	{
		logic full;
		logic empty;
		logic [wr_count_width-1:0] wr_count;
		logic [rd_count_width-1:0] rd_count;
	} fifo_status_t;

endpackage
